//--- build.f
+incdir+testbench
src/lsuPkg.sv
src/lsuIf.sv
src/lsDecode.sv
src/loadStoreBuffer.sv
src/dataMemory.sv
src/loadResult.sv
src/lsuTop.sv
testbench/lsuTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the load/store unit testbench with Verilator, run it and check the log

set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=lsuSim
logFile=sim.log

verilator --binary --timing -f build.f --top-module lsuTb -Mdir "$buildDir" -o "$simName"
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "verilator build failed with status $buildStatus"
    exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1

//--- src/dataMemory.sv
`timescale 1ns/10ps
`default_nettype none

module dataMemory #(
    parameter int memLatency = 3,
    parameter int memWords   = 256
) (
    input wire          clk,
    input wire          rstN,
    memReqIf.memory     memReq
);

    localparam int idxW = $clog2(memWords);
    localparam int cntW = $clog2(memLatency + 1);

    typedef enum logic {
        stIdle,
        stBusy
    } stateE;

    stateE           state;
    logic [cntW-1:0] cnt;
    logic            accept;
    logic            done;

    lsuPkg::dataT mem [memWords];

    logic            opStore;
    lsuPkg::tagT     opTag;
    lsuPkg::sizeT    opSize;
    logic            opUnsigned;
    lsuPkg::addrT    opAddr;
    lsuPkg::dataT    opData;
    logic [3:0]      laneEn;
    lsuPkg::dataT    laneData;
    logic [idxW-1:0] wordIdx;

    assign memReq.memIdle = (state == stIdle);
    assign accept  = memReq.reqVal && memReq.memIdle;
    // last busy cycle; needs a latency of at least two
    assign done    = (state == stBusy) && (cnt == cntW'(1));
    assign wordIdx = opAddr[idxW+1:2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state          <= stIdle;
            cnt            <= '0;
            memReq.respVal <= 1'b0;
        end else begin
            memReq.respVal <= done;
            case (state)
                stIdle: begin
                    if (accept) begin
                        state <= stBusy;
                        cnt   <= cntW'(memLatency - 1);
                    end
                end
                stBusy: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == cntW'(1)) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // byte lanes from size and low address bits
    always_comb begin
        case (opSize)
            lsuPkg::sizeByte: begin
                laneEn   = 4'b0001 << opAddr[1:0];
                laneData = {4{opData[7:0]}};
            end
            lsuPkg::sizeHalf: begin
                laneEn   = opAddr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{opData[15:0]}};
            end
            default: begin
                laneEn   = 4'b1111;
                laneData = opData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opStore    <= memReq.isStore;
            opTag      <= memReq.tag;
            opSize     <= memReq.size;
            opUnsigned <= memReq.unsignedLd;
            opAddr     <= memReq.addr;
            opData     <= memReq.storeData;
        end
        if (done) begin
            memReq.respTag      <= opTag;
            memReq.respIsStore  <= opStore;
            memReq.respSize     <= opSize;
            memReq.respUnsigned <= opUnsigned;
            memReq.respData     <= mem[wordIdx];
            if (opStore) begin
                for (int b = 0; b < 4; b++) begin
                    if (laneEn[b]) begin
                        mem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/loadResult.sv
`timescale 1ns/10ps
`default_nettype none

module loadResult (
    input  wire          clk,
    input  wire          rstN,
    memReqIf.response    memResp,
    resultBusIf.driver   resBus,
    output logic         resultVal,
    output lsuPkg::tagT  resultTag,
    output lsuPkg::dataT resultData,
    output logic         resultIsStore
);

    logic [1:0]   offset;
    lsuPkg::dataT shifted;
    lsuPkg::dataT extended;

    // only one access in flight, so the request offset stays valid
    always_ff @(posedge clk) begin
        if (memResp.reqVal) begin
            offset <= memResp.addr[1:0];
        end
    end

    assign shifted = memResp.respData >> {offset, 3'b000};

    always_comb begin
        case (memResp.respSize)
            lsuPkg::sizeByte: begin
                extended = memResp.respUnsigned ? {24'b0, shifted[7:0]}
                                                : {{24{shifted[7]}}, shifted[7:0]};
            end
            lsuPkg::sizeHalf: begin
                extended = memResp.respUnsigned ? {16'b0, shifted[15:0]}
                                                : {{16{shifted[15]}}, shifted[15:0]};
            end
            default: extended = memResp.respData;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultVal <= 1'b0;
        end else begin
            resultVal <= memResp.respVal;
        end
    end

    always_ff @(posedge clk) begin
        if (memResp.respVal) begin
            resultTag     <= memResp.respTag;
            resultIsStore <= memResp.respIsStore;
            resultData    <= memResp.respIsStore ? '0 : extended;
        end
    end

    // store completions wake nobody
    assign resBus.val  = resultVal && !resultIsStore;
    assign resBus.tag  = resultTag;
    assign resBus.data = resultData;

endmodule

`default_nettype wire

//--- src/loadStoreBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module loadStoreBuffer #(
    parameter int bufDepth = 4
) (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire                 decVal,
    input  wire                 decIsStore,
    input  wire lsuPkg::sizeT   decSize,
    input  wire                 decUnsigned,
    input  wire lsuPkg::tagT    decTag,
    input  wire lsuPkg::immT    decImm,
    input  wire lsuPkg::tagT    decRs1Tag,
    input  wire lsuPkg::dataT   decRs1Data,
    input  wire lsuPkg::tagT    decRs2Tag,
    input  wire lsuPkg::dataT   decRs2Data,
    input  wire                 wbVal,
    input  wire lsuPkg::tagT    wbTag,
    input  wire lsuPkg::dataT   wbData,
    input  wire                 commitVal,
    input  wire lsuPkg::tagT    commitTag,
    resultBusIf.consumer        resBus,
    memReqIf.requester          memReq,
    output logic                dispCredit
);

    localparam int idxW = (bufDepth > 1) ? $clog2(bufDepth) : 1;

    logic [bufDepth-1:0] entVal;
    logic [bufDepth-1:0] entCommitted;
    logic [bufDepth-1:0] entStore;
    logic [bufDepth-1:0] entUnsigned;
    logic [bufDepth-1:0] entReady;
    lsuPkg::sizeT        entSize [bufDepth];
    lsuPkg::tagT         entTag  [bufDepth];
    lsuPkg::immT         entImm  [bufDepth];
    lsuPkg::tagT         rs1Tag  [bufDepth];
    lsuPkg::dataT        rs1Data [bufDepth];
    lsuPkg::tagT         rs2Tag  [bufDepth];
    lsuPkg::dataT        rs2Data [bufDepth];

    logic [idxW-1:0] freeIdx;
    logic [idxW-1:0] issueIdx;
    logic            anyReady;
    logic            issue;

    // a waiting operand hit by either broadcast
    function automatic logic wakeHit(lsuPkg::tagT t);
        return (t != '0) && ((wbVal && wbTag == t) || (resBus.val && resBus.tag == t));
    endfunction

    function automatic lsuPkg::dataT wakeData(lsuPkg::tagT t);
        return (wbVal && wbTag == t) ? wbData : resBus.data;
    endfunction

    // scan downwards so the lowest index wins
    always_comb begin
        freeIdx  = '0;
        issueIdx = '0;
        anyReady = 1'b0;
        for (int i = bufDepth - 1; i >= 0; i--) begin
            entReady[i] = entVal[i] && rs1Tag[i] == '0 && rs2Tag[i] == '0
                          && (!entStore[i] || entCommitted[i]);
            if (!entVal[i]) begin
                freeIdx = idxW'(i);
            end
            if (entReady[i]) begin
                issueIdx = idxW'(i);
                anyReady = 1'b1;
            end
        end
    end

    assign issue      = anyReady && memReq.memIdle;
    assign dispCredit = issue;

    assign memReq.reqVal     = issue;
    assign memReq.isStore    = entStore[issueIdx];
    assign memReq.tag        = entTag[issueIdx];
    assign memReq.size       = entSize[issueIdx];
    assign memReq.unsignedLd = entUnsigned[issueIdx];
    assign memReq.addr       = rs1Data[issueIdx]
                               + {{20{entImm[issueIdx][11]}}, entImm[issueIdx]};
    assign memReq.storeData  = rs2Data[issueIdx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entVal       <= '0;
            entCommitted <= '0;
        end else begin
            for (int i = 0; i < bufDepth; i++) begin
                if (commitVal && entVal[i] && entStore[i] && entTag[i] == commitTag) begin
                    entCommitted[i] <= 1'b1;
                end
            end
            if (issue) begin
                entVal[issueIdx] <= 1'b0;
            end
            if (decVal) begin
                entVal[freeIdx]       <= 1'b1;
                entCommitted[freeIdx] <= decIsStore && commitVal && commitTag == decTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < bufDepth; i++) begin
            if (entVal[i] && wakeHit(rs1Tag[i])) begin
                rs1Tag[i]  <= '0;
                rs1Data[i] <= wakeData(rs1Tag[i]);
            end
            if (entVal[i] && wakeHit(rs2Tag[i])) begin
                rs2Tag[i]  <= '0;
                rs2Data[i] <= wakeData(rs2Tag[i]);
            end
        end
        // operands can also wake while being written
        if (decVal) begin
            entStore[freeIdx]    <= decIsStore;
            entSize[freeIdx]     <= decSize;
            entUnsigned[freeIdx] <= decUnsigned;
            entTag[freeIdx]      <= decTag;
            entImm[freeIdx]      <= decImm;
            rs1Tag[freeIdx]      <= wakeHit(decRs1Tag) ? '0 : decRs1Tag;
            rs1Data[freeIdx]     <= wakeHit(decRs1Tag) ? wakeData(decRs1Tag) : decRs1Data;
            rs2Tag[freeIdx]      <= wakeHit(decRs2Tag) ? '0 : decRs2Tag;
            rs2Data[freeIdx]     <= wakeHit(decRs2Tag) ? wakeData(decRs2Tag) : decRs2Data;
        end
    end

endmodule

`default_nettype wire

//--- src/lsDecode.sv
`timescale 1ns/10ps
`default_nettype none

module lsDecode (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  dispVal,
    input  wire lsuPkg::memOpE   dispOp,
    input  wire lsuPkg::tagT     dispTag,
    input  wire lsuPkg::immT     dispImm,
    input  wire lsuPkg::tagT     dispRs1Tag,
    input  wire lsuPkg::dataT    dispRs1Data,
    input  wire lsuPkg::tagT     dispRs2Tag,
    input  wire lsuPkg::dataT    dispRs2Data,
    output logic                 decVal,
    output logic                 decIsStore,
    output lsuPkg::sizeT         decSize,
    output logic                 decUnsigned,
    output lsuPkg::tagT          decTag,
    output lsuPkg::immT          decImm,
    output lsuPkg::tagT          decRs1Tag,
    output lsuPkg::dataT         decRs1Data,
    output lsuPkg::tagT          decRs2Tag,
    output lsuPkg::dataT         decRs2Data
);

    logic         opKnown;
    logic         opStore;
    logic         opUnsigned;
    lsuPkg::sizeT opSize;

    always_comb begin
        opKnown    = 1'b1;
        opStore    = 1'b0;
        opUnsigned = 1'b0;
        opSize     = lsuPkg::sizeWord;
        case (dispOp)
            lsuPkg::opLb: opSize = lsuPkg::sizeByte;
            lsuPkg::opLh: opSize = lsuPkg::sizeHalf;
            lsuPkg::opLw: opSize = lsuPkg::sizeWord;
            lsuPkg::opLbu: begin
                opSize     = lsuPkg::sizeByte;
                opUnsigned = 1'b1;
            end
            lsuPkg::opLhu: begin
                opSize     = lsuPkg::sizeHalf;
                opUnsigned = 1'b1;
            end
            lsuPkg::opSb: begin
                opSize  = lsuPkg::sizeByte;
                opStore = 1'b1;
            end
            lsuPkg::opSh: begin
                opSize  = lsuPkg::sizeHalf;
                opStore = 1'b1;
            end
            lsuPkg::opSw: opStore = 1'b1;
            // opNone and unused codes
            default: opKnown = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decVal <= 1'b0;
        end else begin
            decVal <= dispVal && opKnown;
        end
    end

    always_ff @(posedge clk) begin
        if (dispVal) begin
            decIsStore  <= opStore;
            decSize     <= opSize;
            decUnsigned <= opUnsigned;
            decTag      <= dispTag;
            decImm      <= dispImm;
            decRs1Tag   <= dispRs1Tag;
            decRs1Data  <= dispRs1Data;
            // loads have no second operand
            decRs2Tag   <= opStore ? dispRs2Tag : '0;
            decRs2Data  <= opStore ? dispRs2Data : '0;
        end
    end

endmodule

`default_nettype wire

//--- src/lsuIf.sv
`timescale 1ns/10ps
`default_nettype none

interface memReqIf;
    logic          reqVal;
    logic          isStore;
    lsuPkg::tagT   tag;
    lsuPkg::sizeT  size;
    logic          unsignedLd;
    lsuPkg::addrT  addr;
    lsuPkg::dataT  storeData;
    logic          memIdle;
    logic          respVal;
    lsuPkg::tagT   respTag;
    logic          respIsStore;
    lsuPkg::sizeT  respSize;
    logic          respUnsigned;
    lsuPkg::dataT  respData;

    modport requester (
        output reqVal, isStore, tag, size, unsignedLd, addr, storeData,
        input  memIdle
    );

    modport memory (
        input  reqVal, isStore, tag, size, unsignedLd, addr, storeData,
        output memIdle,
        output respVal, respTag, respIsStore, respSize, respUnsigned, respData
    );

    // result side also watches the request for the low address bits
    modport response (
        input reqVal, addr,
        input respVal, respTag, respIsStore, respSize, respUnsigned, respData
    );
endinterface

interface resultBusIf;
    logic         val;
    lsuPkg::tagT  tag;
    lsuPkg::dataT data;

    modport driver (output val, tag, data);
    modport consumer (input val, tag, data);
endinterface

`default_nettype wire

//--- src/lsuPkg.sv
`default_nettype none

package lsuPkg;

    typedef logic [31:0] dataT;
    typedef logic [31:0] addrT;
    typedef logic [11:0] immT;

    // zero tag means no producer, value present
    typedef logic [3:0] tagT;

    typedef logic [1:0] sizeT;

    localparam sizeT sizeByte = 2'd0;
    localparam sizeT sizeHalf = 2'd1;
    localparam sizeT sizeWord = 2'd2;

    typedef enum logic [3:0] {
        opNone = 4'd0,
        opLb   = 4'd1,
        opLh   = 4'd2,
        opLw   = 4'd3,
        opLbu  = 4'd4,
        opLhu  = 4'd5,
        opSb   = 4'd6,
        opSh   = 4'd7,
        opSw   = 4'd8
    } memOpE;

endpackage

`default_nettype wire

//--- src/lsuTop.sv
`timescale 1ns/10ps
`default_nettype none

module lsuTop #(
    parameter int bufDepth   = 4,
    parameter int memLatency = 3,
    parameter int memWords   = 256
) (
    input  wire                 clk,
    input  wire                 rstN,
    input  wire                 dispVal,
    input  wire lsuPkg::memOpE  dispOp,
    input  wire lsuPkg::tagT    dispTag,
    input  wire lsuPkg::immT    dispImm,
    input  wire lsuPkg::tagT    dispRs1Tag,
    input  wire lsuPkg::dataT   dispRs1Data,
    input  wire lsuPkg::tagT    dispRs2Tag,
    input  wire lsuPkg::dataT   dispRs2Data,
    output logic                dispCredit,
    input  wire                 wbVal,
    input  wire lsuPkg::tagT    wbTag,
    input  wire lsuPkg::dataT   wbData,
    input  wire                 commitVal,
    input  wire lsuPkg::tagT    commitTag,
    output logic                resultVal,
    output lsuPkg::tagT         resultTag,
    output lsuPkg::dataT        resultData,
    output logic                resultIsStore
);

    logic         decVal;
    logic         decIsStore;
    lsuPkg::sizeT decSize;
    logic         decUnsigned;
    lsuPkg::tagT  decTag;
    lsuPkg::immT  decImm;
    lsuPkg::tagT  decRs1Tag;
    lsuPkg::dataT decRs1Data;
    lsuPkg::tagT  decRs2Tag;
    lsuPkg::dataT decRs2Data;

    memReqIf    memBus ();
    resultBusIf resBus ();

    lsDecode uDecode (
        .clk, .rstN,
        .dispVal, .dispOp, .dispTag, .dispImm,
        .dispRs1Tag, .dispRs1Data, .dispRs2Tag, .dispRs2Data,
        .decVal, .decIsStore, .decSize, .decUnsigned, .decTag, .decImm,
        .decRs1Tag, .decRs1Data, .decRs2Tag, .decRs2Data
    );

    loadStoreBuffer #(.bufDepth(bufDepth)) uBuffer (
        .clk, .rstN,
        .decVal, .decIsStore, .decSize, .decUnsigned, .decTag, .decImm,
        .decRs1Tag, .decRs1Data, .decRs2Tag, .decRs2Data,
        .wbVal, .wbTag, .wbData,
        .commitVal, .commitTag,
        .resBus (resBus),
        .memReq (memBus),
        .dispCredit
    );

    dataMemory #(.memLatency(memLatency), .memWords(memWords)) uMemory (
        .clk, .rstN,
        .memReq (memBus)
    );

    loadResult uResult (
        .clk, .rstN,
        .memResp (memBus),
        .resBus  (resBus),
        .resultVal, .resultTag, .resultData, .resultIsStore
    );

endmodule

`default_nettype wire

//--- testbench/lsuVectors.svh
`ifndef LSU_VECTORS_SVH
`define LSU_VECTORS_SVH

// column order is op, tag, imm, rs1Tag, rs1Data, rs2Data, batch, rnd, wb, wbData
// batch rows are not waited for; rnd takes the store data from the LCG
// wb means rs1 is released by a broadcast of rs1Tag carrying wbData

localparam int numVec = 22;

localparam vecT vecTable [numVec] = '{
    // word round trip
    '{lsuPkg::opSw,  4'h1, 12'h000, 4'h0, 32'h100, 32'h0,    1'b0, 1'b1, 1'b0, 32'h0},
    '{lsuPkg::opLw,  4'h2, 12'h010, 4'h0, 32'h0f0, 32'h0,    1'b0, 1'b0, 1'b0, 32'h0},
    // whole words go first so every lane of the size and sign loads is known
    '{lsuPkg::opSw,  4'h3, 12'h000, 4'h0, 32'h200, 32'h0,    1'b0, 1'b1, 1'b0, 32'h0},
    '{lsuPkg::opSw,  4'h4, 12'h004, 4'h0, 32'h200, 32'h0,    1'b0, 1'b1, 1'b0, 32'h0},
    '{lsuPkg::opSb,  4'h5, 12'h001, 4'h0, 32'h200, 32'ha5,   1'b0, 1'b0, 1'b0, 32'h0},
    '{lsuPkg::opSh,  4'h6, 12'hffe, 4'h0, 32'h208, 32'h9c3e, 1'b0, 1'b0, 1'b0, 32'h0},
    '{lsuPkg::opLb,  4'h7, 12'h001, 4'h0, 32'h200, 32'h0,    1'b0, 1'b0, 1'b0, 32'h0},
    '{lsuPkg::opLbu, 4'h8, 12'h011, 4'h0, 32'h1f0, 32'h0,    1'b0, 1'b0, 1'b0, 32'h0},
    '{lsuPkg::opLh,  4'h9, 12'h000, 4'h0, 32'h206, 32'h0,    1'b0, 1'b0, 1'b0, 32'h0},
    '{lsuPkg::opLhu, 4'ha, 12'hff6, 4'h0, 32'h210, 32'h0,    1'b0, 1'b0, 1'b0, 32'h0},
    '{lsuPkg::opLw,  4'hb, 12'h000, 4'h0, 32'h200, 32'h0,    1'b0, 1'b0, 1'b0, 32'h0},
    // loads on tag f fill every entry and the last row broadcasts it
    '{lsuPkg::opLw,  4'h1, 12'h000, 4'hf, 32'h0,   32'h0,    1'b1, 1'b0, 1'b1, 32'h200},
    '{lsuPkg::opLw,  4'h2, 12'h004, 4'hf, 32'h0,   32'h0,    1'b1, 1'b0, 1'b1, 32'h200},
    '{lsuPkg::opLbu, 4'h3, 12'h001, 4'hf, 32'h0,   32'h0,    1'b1, 1'b0, 1'b1, 32'h200},
    '{lsuPkg::opLh,  4'h4, 12'h006, 4'hf, 32'h0,   32'h0,    1'b0, 1'b0, 1'b1, 32'h200},
    // external wakeup with the base taken from wb
    '{lsuPkg::opSw,  4'h5, 12'h000, 4'h0, 32'h300, 32'h0,    1'b0, 1'b1, 1'b0, 32'h0},
    '{lsuPkg::opLw,  4'h6, 12'h008, 4'he, 32'h0,   32'h0,    1'b0, 1'b0, 1'b1, 32'h2f8},
    // pointer stored at 0x104 and a load based on the load of that pointer
    '{lsuPkg::opSw,  4'h7, 12'h004, 4'h0, 32'h100, 32'h300,  1'b0, 1'b0, 1'b0, 32'h0},
    '{lsuPkg::opLw,  4'hd, 12'h004, 4'h0, 32'h100, 32'h0,    1'b1, 1'b0, 1'b0, 32'h0},
    '{lsuPkg::opLw,  4'h8, 12'h000, 4'hd, 32'h0,   32'h0,    1'b0, 1'b0, 1'b0, 32'h0},
    // store held until commit and read back afterwards
    '{lsuPkg::opSh,  4'h9, 12'h002, 4'h0, 32'h300, 32'h0,    1'b0, 1'b1, 1'b0, 32'h0},
    '{lsuPkg::opLw,  4'ha, 12'h000, 4'h0, 32'h300, 32'h0,    1'b0, 1'b0, 1'b0, 32'h0}
};

`endif

//--- testbench/lsuTb.sv
`timescale 1ns/10ps
`default_nettype none

module lsuTb;

    localparam int bufDepth   = 4;
    localparam int memLatency = 3;
    localparam int memWords   = 256;
    localparam int memBytes   = memWords * 4;
    localparam int addrW      = $clog2(memBytes);
    localparam int gotSize    = 64;

    typedef struct packed {
        lsuPkg::memOpE op;
        lsuPkg::tagT   tag;
        lsuPkg::immT   imm;
        lsuPkg::tagT   rs1Tag;
        lsuPkg::dataT  rs1Data;
        lsuPkg::dataT  rs2Data;
        logic          batch;
        logic          rnd;
        logic          wb;
        lsuPkg::dataT  wbData;
    } vecT;

    typedef struct packed {
        lsuPkg::tagT  tag;
        logic         isStore;
        lsuPkg::dataT data;
    } resT;

    `include "lsuVectors.svh"

    // each table row gets memLatency + 10 cycles
    localparam int watchdogCycles = numVec * (memLatency + 10);

    logic          clk;
    logic          rstN;
    logic          dispVal;
    lsuPkg::memOpE dispOp;
    lsuPkg::tagT   dispTag;
    lsuPkg::immT   dispImm;
    lsuPkg::tagT   dispRs1Tag;
    lsuPkg::dataT  dispRs1Data;
    lsuPkg::tagT   dispRs2Tag;
    lsuPkg::dataT  dispRs2Data;
    logic          dispCredit;
    logic          wbVal;
    lsuPkg::tagT   wbTag;
    lsuPkg::dataT  wbData;
    logic          commitVal;
    lsuPkg::tagT   commitTag;
    logic          resultVal;
    lsuPkg::tagT   resultTag;
    lsuPkg::dataT  resultData;
    logic          resultIsStore;

    // byte-addressed reference memory and the last value per tag
    logic [7:0]   model [memBytes];
    lsuPkg::dataT loadValue [16];
    resT          expArr [numVec];
    resT          gotArr [gotSize];
    vecT          v;
    logic [31:0]  lcgState;
    int expCount;
    int checkedCount;
    int results;
    int creditsBack;
    int dispatched;
    int errors;
    int checks;
    int tests;

    lsuTop #(
        .bufDepth   (bufDepth),
        .memLatency (memLatency),
        .memWords   (memWords)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(watchdogCycles * 8);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // results and credits are sampled mid-cycle
    always @(negedge clk) begin
        if (rstN) begin
            if (dispCredit) begin
                creditsBack++;
            end
            if (resultVal) begin
                if (results < gotSize) begin
                    gotArr[results].tag     = resultTag;
                    gotArr[results].isStore = resultIsStore;
                    gotArr[results].data    = resultData;
                end
                results++;
            end
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic isStoreOp(lsuPkg::memOpE op);
        return op inside {lsuPkg::opSb, lsuPkg::opSh, lsuPkg::opSw};
    endfunction

    function automatic int creditsLeft();
        return bufDepth + creditsBack - dispatched;
    endfunction

    function automatic lsuPkg::dataT readModel(lsuPkg::memOpE op, lsuPkg::addrT a);
        logic [addrW-1:0] i;
        logic [7:0]       b0;
        logic [15:0]      h0;
        i  = a[addrW-1:0];
        b0 = model[i];
        h0 = {model[i + addrW'(1)], model[i]};
        case (op)
            lsuPkg::opLb:  return {{24{b0[7]}}, b0};
            lsuPkg::opLbu: return {24'h0, b0};
            lsuPkg::opLh:  return {{16{h0[15]}}, h0};
            lsuPkg::opLhu: return {16'h0, h0};
            default:       return {model[i + addrW'(3)], model[i + addrW'(2)], h0};
        endcase
    endfunction

    task automatic writeModel(lsuPkg::memOpE op, lsuPkg::addrT a, lsuPkg::dataT d);
        logic [addrW-1:0] i;
        int               n;
        i = a[addrW-1:0];
        n = (op == lsuPkg::opSb) ? 1 : (op == lsuPkg::opSh) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            model[i + addrW'(k)] = d[8*k +: 8];
        end
    endtask

    task automatic compareVal(string name, logic [31:0] got, logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    task automatic waitCycles(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic checkResults();
        while (checkedCount < results) begin
            if (checkedCount >= expCount || checkedCount >= gotSize) begin
                $display("result %0d arrived with no operation waiting for it", checkedCount);
                errors++;
            end else begin
                compareVal("resultTag", 32'(gotArr[checkedCount].tag),
                           32'(expArr[checkedCount].tag));
                compareVal("resultIsStore", 32'(gotArr[checkedCount].isStore),
                           32'(expArr[checkedCount].isStore));
                compareVal("resultData", gotArr[checkedCount].data, expArr[checkedCount].data);
            end
            checkedCount++;
        end
    endtask

    // expected result comes from the reference model at dispatch time
    task automatic dispatchVec(vecT row);
        lsuPkg::dataT base;
        lsuPkg::addrT addr;
        lsuPkg::dataT storeData;
        int           waited;
        waited = 0;
        while (creditsLeft() == 0 && waited < 8 * (memLatency + 10)) begin
            waitCycles(1);
            waited++;
        end
        if (creditsLeft() == 0) begin
            $display("no credit came back to dispatch %s tag %0h", row.op.name(), row.tag);
            errors++;
            return;
        end
        base = row.wb ? row.wbData : (row.rs1Tag != '0) ? loadValue[row.rs1Tag] : row.rs1Data;
        addr = base + {{20{row.imm[11]}}, row.imm};
        storeData = row.rnd ? nextRand() : row.rs2Data;
        expArr[expCount].tag     = row.tag;
        expArr[expCount].isStore = isStoreOp(row.op);
        if (isStoreOp(row.op)) begin
            writeModel(row.op, addr, storeData);
            expArr[expCount].data = '0;
        end else begin
            expArr[expCount].data = readModel(row.op, addr);
            loadValue[row.tag]    = expArr[expCount].data;
        end
        expCount++;
        dispOp      = row.op;
        dispTag     = row.tag;
        dispImm     = row.imm;
        dispRs1Tag  = row.rs1Tag;
        dispRs1Data = row.rs1Data;
        dispRs2Tag  = '0;
        dispRs2Data = storeData;
        dispVal     = 1'b1;
        dispatched++;
        waitCycles(1);
        dispVal = 1'b0;
    endtask

    // nothing may issue until the commit or the wb broadcast
    task automatic releaseVec(vecT row);
        int creditsBefore;
        int resultsBefore;
        creditsBefore = creditsBack;
        resultsBefore = results;
        waitCycles(memLatency + 4);
        if (creditsBack != creditsBefore || results != resultsBefore) begin
            $display("%s tag %0h issued before its release", row.op.name(), row.tag);
            errors++;
        end
        if (isStoreOp(row.op)) begin
            commitVal = 1'b1;
            commitTag = row.tag;
        end else begin
            wbVal  = 1'b1;
            wbTag  = row.rs1Tag;
            wbData = row.wbData;
        end
        waitCycles(1);
        commitVal = 1'b0;
        wbVal     = 1'b0;
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (results < expCount && waited < 4 * (memLatency + 10)) begin
            waitCycles(1);
            waited++;
        end
        if (results < expCount) begin
            $display("timeout: only %0d of %0d results arrived", results, expCount);
            errors++;
        end
        checkResults();
    endtask

    initial begin
        rstN        = 1'b0;
        dispVal     = 1'b0;
        dispOp      = lsuPkg::opNone;
        dispTag     = '0;
        dispImm     = '0;
        dispRs1Tag  = '0;
        dispRs1Data = '0;
        dispRs2Tag  = '0;
        dispRs2Data = '0;
        wbVal       = 1'b0;
        wbTag       = '0;
        wbData      = '0;
        commitVal   = 1'b0;
        commitTag   = '0;
        lcgState    = 32'h9535_8086;
        expCount     = 0;
        checkedCount = 0;
        results      = 0;
        creditsBack  = 0;
        dispatched   = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int i = 0; i < numVec; i++) begin
            v = vecTable[i];
            dispatchVec(v);
            if (!v.batch) begin
                if (isStoreOp(v.op) || v.wb) begin
                    releaseVec(v);
                end
                drainResults();
                compareVal("dispCredit count", 32'(creditsLeft()), 32'(bufDepth));
                tests++;
                $display("test %0d %s tag %0h done, %0d errors so far",
                         tests, v.op.name(), v.tag, errors);
            end
        end
        // catch any stray result
        waitCycles(memLatency + 4);
        checkResults();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
